// ==== Bender.yml ====
package:
  name: pwm_peripheral

sources:
  - logic/pwmPkg.sv
  - logic/pwmTimebase.sv
  - logic/pwmChannel.sv
  - logic/pwmDevice.sv
  - logic/pwmBusControl.sv
  - logic/pwmTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/pwmTb.sv

// ==== list.f ====
+incdir+include
logic/pwmPkg.sv
logic/pwmTimebase.sv
logic/pwmChannel.sv
logic/pwmDevice.sv
logic/pwmBusControl.sv
logic/pwmTop.sv
test/pwmTb.sv

// ==== logic/pwmBusControl.sv ====
`timescale 1ns/1ps

module pwmBusControl import pwmPkg::*; (
	input logic clk,
	input logic rst,
	input busRequest_t request,
	output busResponse_t response,
	output deviceConfig_t [DEVICE_COUNT-1:0] deviceConfig,
	output logic [DEVICE_COUNT-1:0] restart
);

	logic peripheralEnable;
	logic [3:0] deviceNumber;
	logic [3:0] deviceOffset;
	logic deviceValid;
	logic [DEVICE_INDEX_WIDTH-1:0] deviceIndex;
	logic [7:0] offset;
	logic [7:0] compareOffset;
	logic compareHit;
	logic [COMPARE_INDEX_WIDTH-1:0] compareIndex;
	logic regMapped;
	logic [DATA_WIDTH-1:0] regData;
	logic [DATA_WIDTH-1:0] writeValue;
	logic accessHit;
	logic readHit;
	logic writeHit;
	deviceConfig_t selected;

	function automatic logic [DATA_WIDTH-1:0] mergeBytes(
		input logic [DATA_WIDTH-1:0] current,
		input logic [DATA_WIDTH-1:0] data,
		input logic [BYTE_COUNT-1:0] select
	);
		logic [DATA_WIDTH-1:0] merged;
		merged = current;
		for (int b = 0; b < BYTE_COUNT; b++) begin
			if (select[b]) begin
				merged[b*8 +: 8] = data[b*8 +: 8];
			end
		end
		return merged;
	endfunction

	// ==============================
	// address decode
	// ==============================
	assign peripheralEnable = request.address[23:16] == PERIPHERAL_ID;
	assign deviceNumber = request.address[11:8];
	assign deviceValid = (deviceNumber >= 4'd1) && (deviceNumber <= DEVICE_COUNT);
	assign deviceOffset = deviceNumber - 4'd1;
	assign deviceIndex = deviceOffset[DEVICE_INDEX_WIDTH-1:0];
	assign offset = request.address[7:0];

	// compare n at base + 4n
	assign compareOffset = offset - REG_COMPARE_BASE;
	assign compareIndex = compareOffset[COMPARE_INDEX_WIDTH+1:2];
	assign compareHit = (offset >= REG_COMPARE_BASE)
		&& (compareOffset < 8'(4 * OUTPUTS_PER_DEVICE))
		&& (offset[1:0] == 2'b00);

	assign selected = deviceConfig[deviceIndex];

	// current contents of the addressed register
	always_comb begin
		regMapped = 1'b1;
		regData = '0;
		if (compareHit) begin
			regData = DATA_WIDTH'(selected.compare[compareIndex]);
		end else begin
			case (offset)
				REG_CONTROL: regData = DATA_WIDTH'({selected.enableMask, 3'b000, selected.run});
				REG_PRESCALE: regData = DATA_WIDTH'(selected.prescale);
				REG_PERIOD: regData = DATA_WIDTH'(selected.period);
				default: regMapped = 1'b0;
			endcase
		end
	end

	assign accessHit = peripheralEnable && deviceValid && regMapped;
	assign readHit = request.oe && accessHit;
	assign writeHit = request.we && accessHit;
	assign writeValue = mergeBytes(regData, request.dataWrite, request.byteSelect);

	assign response.requestOutput = readHit;
	assign response.dataRead = readHit ? regData : '0;

	// ==============================
	// register file
	// ==============================
	always_ff @(posedge clk) begin
		if (rst) begin
			deviceConfig <= '0;
			restart <= '0;
		end else begin
			restart <= '0;
			if (writeHit) begin
				if (compareHit) begin
					deviceConfig[deviceIndex].compare[compareIndex] <= writeValue[PWM_WIDTH-1:0];
				end else begin
					case (offset)
						REG_CONTROL: begin
							deviceConfig[deviceIndex].run <= writeValue[0];
							deviceConfig[deviceIndex].enableMask <= writeValue[7:4];
							restart[deviceIndex] <= 1'b1;
						end
						REG_PRESCALE: deviceConfig[deviceIndex].prescale <= writeValue;
						REG_PERIOD: deviceConfig[deviceIndex].period <= writeValue[PWM_WIDTH-1:0];
						default: ;
					endcase
				end
			end
		end
	end

endmodule

// ==== logic/pwmChannel.sv ====
`timescale 1ns/1ps

module pwmChannel import pwmPkg::*; (
	input logic clk,
	input logic rst,
	input logic run,
	input logic enable,
	input logic [PWM_WIDTH-1:0] count,
	input logic [PWM_WIDTH-1:0] compare,
	output logic pwmEn,
	output logic pwmOut
);

	logic level;

	// zero compare stays low and compare above period stays high
	assign level = run && (count < compare);

	always_ff @(posedge clk) begin
		if (rst) begin
			pwmOut <= 1'b0;
			pwmEn <= 1'b0;
		end else begin
			pwmOut <= level;
			pwmEn <= run && enable;
		end
	end

endmodule

// ==== logic/pwmDevice.sv ====
`timescale 1ns/1ps

module pwmDevice import pwmPkg::*; (
	input logic clk,
	input logic rst,
	input deviceConfig_t deviceConfig,
	input logic restart,
	output logic [OUTPUTS_PER_DEVICE-1:0] pwmEn,
	output logic [OUTPUTS_PER_DEVICE-1:0] pwmOut
);

	// shared by every channel of this device
	logic [PWM_WIDTH-1:0] count;

	pwmTimebase timebase (
		.clk(clk),
		.rst(rst),
		.run(deviceConfig.run),
		.restart(restart),
		.prescale(deviceConfig.prescale),
		.period(deviceConfig.period),
		.count(count)
	);

	// ==============================
	// compare channels
	// ==============================
	for (genvar i = 0; i < OUTPUTS_PER_DEVICE; i++) begin : channelGen
		pwmChannel channel (
			.clk(clk),
			.rst(rst),
			.run(deviceConfig.run),
			.enable(deviceConfig.enableMask[i]),
			.count(count),
			.compare(deviceConfig.compare[i]),
			.pwmEn(pwmEn[i]),
			.pwmOut(pwmOut[i])
		);
	end

endmodule

// ==== logic/pwmPkg.sv ====
package pwmPkg;

	// ==============================
	// sizes
	// ==============================
	localparam logic [7:0] PERIPHERAL_ID = 8'h02;
	localparam int DEVICE_COUNT = 4;
	localparam int OUTPUTS_PER_DEVICE = 4;
	localparam int PWM_WIDTH = 16;
	localparam int PRESCALE_WIDTH = 32;
	localparam int ADDRESS_WIDTH = 24;
	localparam int DATA_WIDTH = 32;
	localparam int BYTE_COUNT = DATA_WIDTH / 8;
	localparam int DEVICE_INDEX_WIDTH = $clog2(DEVICE_COUNT);
	localparam int COMPARE_INDEX_WIDTH = $clog2(OUTPUTS_PER_DEVICE);

	// ==============================
	// register map
	// ==============================
	// byte offsets inside one device
	// device number sits in address bits 11:8
	localparam logic [7:0] REG_CONTROL = 8'h00;
	localparam logic [7:0] REG_PRESCALE = 8'h04;
	localparam logic [7:0] REG_PERIOD = 8'h08;
	localparam logic [7:0] REG_COMPARE_BASE = 8'h10;

	typedef struct packed {
		logic we;
		logic oe;
		logic [ADDRESS_WIDTH-1:0] address;
		logic [BYTE_COUNT-1:0] byteSelect;
		logic [DATA_WIDTH-1:0] dataWrite;
	} busRequest_t;

	typedef struct packed {
		logic [DATA_WIDTH-1:0] dataRead;
		logic requestOutput;
	} busResponse_t;

	// one device worth of settings
	typedef struct packed {
		logic run;
		logic [OUTPUTS_PER_DEVICE-1:0] enableMask;
		logic [PRESCALE_WIDTH-1:0] prescale;
		logic [PWM_WIDTH-1:0] period;
		logic [OUTPUTS_PER_DEVICE-1:0][PWM_WIDTH-1:0] compare;
	} deviceConfig_t;

endpackage

// ==== logic/pwmTimebase.sv ====
`timescale 1ns/1ps

module pwmTimebase import pwmPkg::*; (
	input logic clk,
	input logic rst,
	input logic run,
	input logic restart,
	input logic [PRESCALE_WIDTH-1:0] prescale,
	input logic [PWM_WIDTH-1:0] period,
	output logic [PWM_WIDTH-1:0] count
);

	logic [PRESCALE_WIDTH-1:0] prescaler;
	logic prescaleWrap;
	logic periodWrap;

	// >= so a smaller limit written mid-cycle still wraps
	assign prescaleWrap = prescaler >= prescale;
	assign periodWrap = count >= period;

	always_ff @(posedge clk) begin
		if (rst) begin
			prescaler <= '0;
			count <= '0;
		end else if (!run || restart) begin
			// held at zero while stopped or restarting
			prescaler <= '0;
			count <= '0;
		end else if (prescaleWrap) begin
			prescaler <= '0;
			if (periodWrap) begin
				count <= '0;
			end else begin
				count <= count + 1'b1;
			end
		end else begin
			prescaler <= prescaler + 1'b1;
		end
	end

endmodule

// ==== logic/pwmTop.sv ====
`timescale 1ns/1ps

module pwmTop import pwmPkg::*; (
	input logic clk,
	input logic rst,
	input busRequest_t request,
	output busResponse_t response,
	output logic [DEVICE_COUNT*OUTPUTS_PER_DEVICE-1:0] pwmEn,
	output logic [DEVICE_COUNT*OUTPUTS_PER_DEVICE-1:0] pwmOut
);

	deviceConfig_t [DEVICE_COUNT-1:0] deviceConfig;
	logic [DEVICE_COUNT-1:0] restart;

	pwmBusControl busControl (
		.clk(clk),
		.rst(rst),
		.request(request),
		.response(response),
		.deviceConfig(deviceConfig),
		.restart(restart)
	);

	// device i owns outputs 4i to 4i+3
	for (genvar i = 0; i < DEVICE_COUNT; i++) begin : deviceGen
		pwmDevice device (
			.clk(clk),
			.rst(rst),
			.deviceConfig(deviceConfig[i]),
			.restart(restart[i]),
			.pwmEn(pwmEn[i*OUTPUTS_PER_DEVICE +: OUTPUTS_PER_DEVICE]),
			.pwmOut(pwmOut[i*OUTPUTS_PER_DEVICE +: OUTPUTS_PER_DEVICE])
		);
	end

endmodule

// ==== include/pwmTbTasks.svh ====
`ifndef PWM_TB_TASKS_SVH
`define PWM_TB_TASKS_SVH

// ==============================
// bus access and checks
// ==============================
task automatic busWrite(input logic [ADDRESS_WIDTH-1:0] address,
		input logic [DATA_WIDTH-1:0] data, input logic [BYTE_COUNT-1:0] select);
	@(posedge clk);
	#10;
	request.we = 1'b1;
	request.oe = 1'b0;
	request.address = address;
	request.byteSelect = select;
	request.dataWrite = data;
	@(posedge clk);
	#10;
	request = '0;
endtask

// combinational response sampled at the falling edge
task automatic busRead(input logic [ADDRESS_WIDTH-1:0] address, output busResponse_t got);
	@(posedge clk);
	#10;
	request = '0;
	request.oe = 1'b1;
	request.address = address;
	@(negedge clk);
	got = response;
	@(posedge clk);
	#10;
	request = '0;
endtask

task automatic checkResponse(input string name, input busResponse_t got,
		input busResponse_t expected);
	checksRun++;
	if (got.requestOutput !== expected.requestOutput) begin
		errorCount++;
		$display("[ERROR] %s.requestOutput got %h expected %h", name, got.requestOutput,
			expected.requestOutput);
	end
	if (got.dataRead !== expected.dataRead) begin
		errorCount++;
		$display("[ERROR] %s.dataRead got %h expected %h", name, got.dataRead,
			expected.dataRead);
	end
endtask

task automatic checkOutputs(input string name, input logic [OUTPUT_COUNT-1:0] got,
		input logic [OUTPUT_COUNT-1:0] expected);
	checksRun++;
	if (got !== expected) begin
		errorCount++;
		$display("[ERROR] %s got %h expected %h", name, got, expected);
	end
endtask

task automatic checkHighCount(input int channel, input int got, input int expected);
	checksRun++;
	if (got != expected) begin
		errorCount++;
		$display("[ERROR] pwmOut[%0d] high cycles got %h expected %h", channel, got, expected);
	end
endtask

// high cycles of each output over its own window
// all windows start on the same edge
task automatic countHigh(input int cycles);
	for (int i = 0; i < OUTPUT_COUNT; i++) begin
		highCount[i] = 0;
	end
	for (int c = 0; c < cycles; c++) begin
		@(negedge clk);
		for (int i = 0; i < OUTPUT_COUNT; i++) begin
			if (c < windowLen[i] && pwmOut[i]) begin
				highCount[i]++;
			end
		end
	end
endtask

// ==============================
// register model
// ==============================
function automatic logic [ADDRESS_WIDTH-1:0] regAddress(input int dev, input int idx);
	logic [7:0] offset;
	case (idx)
		0: offset = REG_CONTROL;
		1: offset = REG_PRESCALE;
		2: offset = REG_PERIOD;
		default: offset = REG_COMPARE_BASE + 8'((idx - 3) * 4);
	endcase
	return {PERIPHERAL_ID, 4'h0, 4'(dev), offset};
endfunction

// bits that each register implements
function automatic logic [DATA_WIDTH-1:0] regMask(input int idx);
	case (idx)
		0: return 32'h0000_00F1;
		1: return 32'hFFFF_FFFF;
		default: return 32'h0000_FFFF;
	endcase
endfunction

task automatic writeReg(input int dev, input int idx, input logic [DATA_WIDTH-1:0] value,
		input logic [BYTE_COUNT-1:0] select);
	logic [DATA_WIDTH-1:0] merged;
	merged = regModel[dev-1][idx];
	for (int b = 0; b < BYTE_COUNT; b++) begin
		if (select[b]) begin
			merged[b*8 +: 8] = value[b*8 +: 8];
		end
	end
	regModel[dev-1][idx] = merged & regMask(idx);
	busWrite(regAddress(dev, idx), value, select);
endtask

task automatic verifyAll();
	busResponse_t got;
	busResponse_t expected;
	for (int dev = 1; dev <= DEVICE_COUNT; dev++) begin
		for (int idx = 0; idx < REG_COUNT; idx++) begin
			busRead(regAddress(dev, idx), got);
			expected.requestOutput = 1'b1;
			expected.dataRead = regModel[dev-1][idx];
			checkResponse($sformatf("dev%0d reg%0d", dev, idx), got, expected);
		end
	end
endtask

task automatic checkUnmapped(input string name, input logic [ADDRESS_WIDTH-1:0] address);
	busResponse_t got;
	busWrite(address, $urandom, 4'hF);
	busRead(address, got);
	checkResponse(name, got, '0);
endtask

// ==============================
// directed tests
// ==============================
task automatic testResetState();
	checkOutputs("pwmOut", pwmOut, '0);
	checkOutputs("pwmEn", pwmEn, '0);
	verifyAll();
endtask

task automatic testRegisterAccess();
	for (int dev = 1; dev <= DEVICE_COUNT; dev++) begin
		for (int idx = 0; idx < REG_COUNT; idx++) begin
			writeReg(dev, idx, $urandom, 4'hF);
		end
	end
	verifyAll();
	// partial byte selects on prescale and one compare per device
	for (int dev = 1; dev <= DEVICE_COUNT; dev++) begin
		writeReg(dev, 1, $urandom, 4'($urandom_range(1, 14)));
		writeReg(dev, 2 + dev, $urandom, 4'($urandom_range(1, 14)));
	end
	verifyAll();
endtask

task automatic testAddressDecode();
	checkUnmapped("wrong id", {8'h03, 4'h0, 4'h1, REG_PRESCALE});
	checkUnmapped("device 0", {PERIPHERAL_ID, 4'h0, 4'h0, REG_PRESCALE});
	checkUnmapped("device 5", {PERIPHERAL_ID, 4'h0, 4'h5, REG_PRESCALE});
	checkUnmapped("offset 0c", {PERIPHERAL_ID, 4'h0, 4'h1, 8'h0C});
	checkUnmapped("offset 12", {PERIPHERAL_ID, 4'h0, 4'h2, 8'h12});
	verifyAll();
endtask

task automatic testDutyCycle();
	int prescale;
	int period;
	int compare;
	int longest;
	longest = 0;
	for (int dev = 1; dev <= DEVICE_COUNT; dev++) begin
		prescale = $urandom_range(0, 3);
		period = $urandom_range(1, 15);
		writeReg(dev, 0, 32'h0, 4'hF);
		writeReg(dev, 1, 32'(prescale), 4'hF);
		writeReg(dev, 2, 32'(period), 4'hF);
		for (int ch = 0; ch < OUTPUTS_PER_DEVICE; ch++) begin
			compare = $urandom_range(0, period + 2);
			writeReg(dev, 3 + ch, 32'(compare), 4'hF);
			// two whole PWM cycles so the phase drops out
			windowLen[(dev-1)*4 + ch] = 2 * (prescale + 1) * (period + 1);
			expectedHigh[(dev-1)*4 + ch] = 2 * (prescale + 1)
				* ((compare < period + 1) ? compare : period + 1);
		end
		if (windowLen[(dev-1)*4] > longest) begin
			longest = windowLen[(dev-1)*4];
		end
	end
	for (int dev = 1; dev <= DEVICE_COUNT; dev++) begin
		writeReg(dev, 0, 32'h0000_00F1, 4'hF);
	end
	// let the last restart settle
	repeat (4) @(posedge clk);
	countHigh(longest);
	for (int i = 0; i < OUTPUT_COUNT; i++) begin
		checkHighCount(i, highCount[i], expectedHigh[i]);
	end
endtask

task automatic testEnableMask();
	logic [OUTPUT_COUNT-1:0] expectedEn;
	logic [OUTPUT_COUNT-1:0] seenHigh;
	logic [OUTPUT_COUNT-1:0] seenLow;
	logic [OUTPUT_COUNT-1:0] devBits;
	logic [3:0] mask;
	expectedEn = '0;
	for (int dev = 1; dev <= DEVICE_COUNT; dev++) begin
		writeReg(dev, 1, 32'h0, 4'hF);
		writeReg(dev, 2, 32'h3, 4'hF);
		for (int ch = 0; ch < OUTPUTS_PER_DEVICE; ch++) begin
			writeReg(dev, 3 + ch, 32'h2, 4'hF);
		end
		// at least one channel enabled and one masked in every device
		mask = 4'($urandom_range(1, 14));
		writeReg(dev, 0, {24'h0, mask, 4'h1}, 4'hF);
		expectedEn[(dev-1)*4 +: 4] = mask;
	end
	@(posedge clk);
	@(negedge clk);
	checkOutputs("pwmEn", pwmEn, expectedEn);
	// every output toggles whether masked or not
	seenHigh = '0;
	seenLow = '0;
	repeat (8) begin
		@(negedge clk);
		seenHigh = seenHigh | pwmOut;
		seenLow = seenLow | ~pwmOut;
	end
	checkOutputs("pwmOut toggled", seenHigh & seenLow, '1);
	for (int dev = 1; dev <= DEVICE_COUNT; dev++) begin
		devBits = OUTPUT_COUNT'(4'hF) << ((dev - 1) * 4);
		writeReg(dev, 0, {24'h0, expectedEn[(dev-1)*4 +: 4], 4'h0}, 4'hF);
		@(posedge clk);
		@(negedge clk);
		checkOutputs($sformatf("dev%0d pwmOut", dev), pwmOut & devBits, '0);
		checkOutputs($sformatf("dev%0d pwmEn", dev), pwmEn & devBits, '0);
	end
endtask

`endif

// ==== test/pwmTb.sv ====
`timescale 1ns/1ps

module pwmTb import pwmPkg::*; ();

	localparam int OUTPUT_COUNT = DEVICE_COUNT * OUTPUTS_PER_DEVICE;
	localparam int REG_COUNT = 3 + OUTPUTS_PER_DEVICE;
	// a few hundred two-cycle accesses plus a duty window of at most 2*4*16 clocks
	localparam int TIMEOUT_CYCLES = 20000;

	logic clk;
	logic rst;
	busRequest_t request;
	busResponse_t response;
	logic [OUTPUT_COUNT-1:0] pwmEn;
	logic [OUTPUT_COUNT-1:0] pwmOut;

	// expected register contents per device
	// index 0 control, 1 prescale, 2 period, 3 and up compare
	logic [DATA_WIDTH-1:0] regModel [DEVICE_COUNT][REG_COUNT];
	int windowLen [OUTPUT_COUNT];
	int expectedHigh [OUTPUT_COUNT];
	int highCount [OUTPUT_COUNT];
	int errorCount;
	int checksRun;
	int cycleCount;
	int seed;

	pwmTop pwmTop_inst (
		.clk(clk),
		.rst(rst),
		.request(request),
		.response(response),
		.pwmEn(pwmEn),
		.pwmOut(pwmOut)
	);

	`include "pwmTbTasks.svh"

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the tests did not finish", cycleCount);
			$display("Errors found");
			$finish;
		end
	end

	initial begin
		rst = 1'b1;
		request = '0;
		errorCount = 0;
		checksRun = 0;
		cycleCount = 0;
		seed = 63740;
		void'($urandom(seed));
		for (int d = 0; d < DEVICE_COUNT; d++) begin
			for (int r = 0; r < REG_COUNT; r++) begin
				regModel[d][r] = '0;
			end
		end
		repeat (5) @(posedge clk);
		#10;
		rst = 1'b0;

		testResetState();
		testRegisterAccess();
		testAddressDecode();
		testDutyCycle();
		testEnableMask();

		$display("checks: %0d, errors: %0d", checksRun, errorCount);
		if (errorCount == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule
